// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // ----------------------------------------
    // Opcodes and function fields
    // ----------------------------------------
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    // ----------------------------------------
    // Instruction word views
    // ----------------------------------------
    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        shamt;
        logic [5:0]        funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    // ----------------------------------------
    // Control and stage registers
    // ----------------------------------------
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [XLEN-1:0]   pc4;
        logic [XLEN-1:0]   rs_data;
        logic [XLEN-1:0]   rt_data;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [XLEN-1:0]   br_target;
        logic [XLEN-1:0]   alu_res;
        logic              zero;
        logic [XLEN-1:0]   st_data;
        logic [REG_AW-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        logic              reg_write;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage

// ==== hdl/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch #(
    parameter int IMEM_AW = 8
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_preload_en,
    input  logic [mips_pkg::XLEN-1:0] i_preload_addr,
    input  logic [mips_pkg::XLEN-1:0] i_preload_instr,
    input  logic                     i_stall,
    input  logic                     i_branch_taken,
    input  logic [mips_pkg::XLEN-1:0] i_branch_target,
    output mips_pkg::if_id_t         o_if_id
);
    import mips_pkg::*;

    logic [XLEN-1:0] imem [2**IMEM_AW];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc4;

    assign pc4 = pc + XLEN'(4);

    // Preload port stays live during reset
    always_ff @(posedge i_clk) begin
        if (i_preload_en) begin
            imem[i_preload_addr[IMEM_AW-1:0]] <= i_preload_instr;
        end
    end

    // Branch redirect wins over stall
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc      <= '0;
            o_if_id <= '0;
        end else if (i_branch_taken) begin
            pc      <= i_branch_target;
            o_if_id <= '0;
        end else if (!i_stall) begin
            pc            <= pc4;
            o_if_id.pc4   <= pc4;
            o_if_id.instr <= imem[pc[IMEM_AW+1:2]];
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic [mips_pkg::REG_AW-1:0] i_rs,
    input  logic [mips_pkg::REG_AW-1:0] i_rt,
    input  mips_pkg::wb_t              i_wb,
    output logic [mips_pkg::XLEN-1:0]   o_rs_data,
    output logic [mips_pkg::XLEN-1:0]   o_rt_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];

    // Register 0 reads as zero and a same-cycle write passes straight through
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_wb.reg_write && (i_wb.dest == idx)) begin
            return i_wb.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int k = 0; k < 2**REG_AW; k++) begin
                regs[k] <= '0;
            end
        end else if (i_wb.reg_write && (i_wb.dest != '0)) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    assign o_rs_data = read_port(i_rs);
    assign o_rt_data = read_port(i_rt);

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic              i_clk,
    input  logic              i_rst,
    input  mips_pkg::if_id_t  i_if_id,
    input  mips_pkg::wb_t     i_wb,
    input  mips_pkg::id_ex_t  i_id_ex_fb,
    input  logic              i_branch_taken,
    output logic              o_stall,
    output mips_pkg::id_ex_t  o_id_ex
);
    import mips_pkg::*;

    instr_u            instr;
    ctrl_t             ctrl;
    logic [REG_AW-1:0] dest;
    logic              uses_rt;
    logic [XLEN-1:0]   imm_ext;
    logic [XLEN-1:0]   rs_data;
    logic [XLEN-1:0]   rt_data;
    logic              load_hit;

    assign instr   = i_if_id.instr;
    assign imm_ext = {{(XLEN-16){instr.i.imm[15]}}, instr.i.imm};

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs      (instr.r.rs),
        .i_rt      (instr.r.rt),
        .i_wb      (i_wb),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // ----------------------------------------
    // Control decode
    // ----------------------------------------
    always_comb begin
        ctrl    = '0;
        dest    = '0;
        uses_rt = 1'b0;
        case (instr.r.opcode)
            OP_RTYPE: begin
                uses_rt        = 1'b1;
                dest           = instr.r.rd;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    // Unknown funct runs as a no-op
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDI: begin
                dest           = instr.i.rt;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                dest            = instr.i.rt;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
                uses_rt        = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                uses_rt     = 1'b1;
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            default: begin
                ctrl = '0;
            end
        endcase
        // Register 0 is never written
        if (dest == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    // Load in EX feeding an operand read here
    assign load_hit = i_id_ex_fb.ctrl.mem_read && (i_id_ex_fb.dest != '0);
    assign o_stall  = load_hit && ((i_id_ex_fb.dest == instr.r.rs)
                      || (uses_rt && (i_id_ex_fb.dest == instr.r.rt)));

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst || o_stall || i_branch_taken) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.ctrl    <= ctrl;
            o_id_ex.pc4     <= i_if_id.pc4;
            o_id_ex.rs_data <= rs_data;
            o_id_ex.rt_data <= rt_data;
            o_id_ex.imm     <= imm_ext;
            o_id_ex.rs      <= instr.r.rs;
            o_id_ex.rt      <= instr.r.rt;
            o_id_ex.dest    <= dest;
        end
    end

endmodule

// ==== hdl/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit (
    input  mips_pkg::id_ex_t   i_id_ex,
    input  mips_pkg::ex_mem_t  i_ex_mem,
    input  mips_pkg::wb_t      i_mem_wb,
    output mips_pkg::fwd_sel_e o_fwd_a,
    output mips_pkg::fwd_sel_e o_fwd_b
);
    import mips_pkg::*;

    // Younger result in EX/MEM takes priority over MEM/WB
    function automatic fwd_sel_e pick(input logic [REG_AW-1:0] src);
        if (i_ex_mem.ctrl.reg_write && (i_ex_mem.dest != '0) && (i_ex_mem.dest == src)) begin
            return FWD_EX_MEM;
        end
        if (i_mem_wb.reg_write && (i_mem_wb.dest != '0) && (i_mem_wb.dest == src)) begin
            return FWD_MEM_WB;
        end
        return FWD_REG;
    endfunction

    assign o_fwd_a = pick(i_id_ex.rs);
    assign o_fwd_b = pick(i_id_ex.rt);

endmodule

// ==== hdl/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic              i_clk,
    input  logic              i_rst,
    input  mips_pkg::id_ex_t  i_id_ex,
    input  mips_pkg::wb_t     i_mem_wb,
    input  logic              i_branch_taken,
    output mips_pkg::ex_mem_t o_ex_mem
);
    import mips_pkg::*;

    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b_reg;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] br_target;

    forward_unit u_forward_unit (
        .i_id_ex  (i_id_ex),
        .i_ex_mem (o_ex_mem),
        .i_mem_wb (i_mem_wb),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b)
    );

    // ----------------------------------------
    // Operand muxes
    // ----------------------------------------
    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_EX_MEM: return o_ex_mem.alu_res;
            FWD_MEM_WB: return i_mem_wb.data;
            default:    return reg_val;
        endcase
    endfunction

    assign op_a     = fwd_mux(fwd_a, i_id_ex.rs_data);
    assign op_b_reg = fwd_mux(fwd_b, i_id_ex.rt_data);
    assign op_b     = i_id_ex.ctrl.alu_src ? i_id_ex.imm : op_b_reg;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = XLEN'($signed(op_a) < $signed(op_b));
            default: alu_res = op_a + op_b;
        endcase
    end

    // Word offset relative to PC plus 4
    assign br_target = i_id_ex.pc4 + {i_id_ex.imm[XLEN-3:0], 2'b00};

    // ----------------------------------------
    // EX/MEM register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst || i_branch_taken) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.ctrl      <= i_id_ex.ctrl;
            o_ex_mem.br_target <= br_target;
            o_ex_mem.alu_res   <= alu_res;
            o_ex_mem.zero      <= (alu_res == '0);
            o_ex_mem.st_data   <= op_b_reg;
            o_ex_mem.dest      <= i_id_ex.dest;
        end
    end

endmodule

// ==== hdl/mem_access.sv ====
`timescale 1ns/1ps

module mem_access #(
    parameter int DMEM_AW = 8
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  mips_pkg::ex_mem_t        i_ex_mem,
    output logic                     o_branch_taken,
    output logic [mips_pkg::XLEN-1:0] o_branch_target,
    output mips_pkg::wb_t            o_mem_wb
);
    import mips_pkg::*;

    logic [XLEN-1:0]    dmem [2**DMEM_AW];
    logic [DMEM_AW-1:0] word_addr;
    logic [XLEN-1:0]    rd_data;

    assign word_addr = i_ex_mem.alu_res[DMEM_AW+1:2];
    assign rd_data   = i_ex_mem.ctrl.mem_read ? dmem[word_addr] : '0;

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.ctrl.mem_write) begin
            dmem[word_addr] <= i_ex_mem.st_data;
        end
    end

    // BEQ resolves here
    assign o_branch_taken  = i_ex_mem.ctrl.branch && i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.br_target;

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_mem_wb <= '0;
        end else begin
            o_mem_wb.reg_write <= i_ex_mem.ctrl.reg_write;
            o_mem_wb.dest      <= i_ex_mem.dest;
            o_mem_wb.data      <= i_ex_mem.ctrl.mem_to_reg ? rd_data : i_ex_mem.alu_res;
        end
    end

endmodule

// ==== hdl/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_preload_en,
    input  logic [mips_pkg::XLEN-1:0] i_preload_addr,
    input  logic [mips_pkg::XLEN-1:0] i_preload_instr,
    output mips_pkg::wb_t            o_wb
);
    import mips_pkg::*;

    // ----------------------------------------
    // Stage links
    // ----------------------------------------
    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    logic            stall;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;

    instr_fetch #(
        .IMEM_AW (IMEM_AW)
    ) u_instr_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_preload_en    (i_preload_en),
        .i_preload_addr  (i_preload_addr),
        .i_preload_instr (i_preload_instr),
        .i_stall         (stall),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_if_id         (if_id)
    );

    instr_decode u_instr_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_if_id        (if_id),
        .i_wb           (o_wb),
        .i_id_ex_fb     (id_ex),
        .i_branch_taken (branch_taken),
        .o_stall        (stall),
        .o_id_ex        (id_ex)
    );

    execute u_execute (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_id_ex        (id_ex),
        .i_mem_wb       (o_wb),
        .i_branch_taken (branch_taken),
        .o_ex_mem       (ex_mem)
    );

    // MEM/WB doubles as the retirement trace
    mem_access #(
        .DMEM_AW (DMEM_AW)
    ) u_mem_access (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_ex_mem        (ex_mem),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_mem_wb        (o_wb)
    );

endmodule

// ==== sim/mips_core_sva.sv ====
`timescale 1ns/1ps

module mips_core_sva (
    input logic          i_clk,
    input logic          i_rst,
    input mips_pkg::wb_t i_wb
);

    // A reset edge clears the MEM/WB register
    property p_quiet_in_reset;
        @(posedge i_clk) !i_rst |=> !i_wb.reg_write;
    endproperty

    property p_no_r0_write;
        @(posedge i_clk) i_wb.reg_write |-> (i_wb.dest != '0);
    endproperty

    property p_known_data;
        @(posedge i_clk) i_wb.reg_write |-> !$isunknown(i_wb.data);
    endproperty

    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else $error("o_wb.reg_write high after a reset edge");

    a_no_r0_write: assert property (p_no_r0_write)
        else $error("o_wb reports a write to register 0");

    a_known_data: assert property (p_known_data)
        else $error("o_wb.data has unknown bits on a write");

endmodule

bind mips_core mips_core_sva u_wb_sva (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_wb  (o_wb)
);

// ==== sim/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;
    import mips_pkg::*;

    localparam int NUM_TESTS  = 5;
    localparam int PROG_WORDS = 16;
    localparam int WB_TIMEOUT = 64;
    localparam int QUIET_CYC  = 8;

    logic            i_clk;
    logic            i_rst;
    logic            i_preload_en;
    logic [XLEN-1:0] i_preload_addr;
    logic [XLEN-1:0] i_preload_instr;
    wb_t             o_wb;

    // Program table with the expected register writes
    string           test_name [NUM_TESTS];
    logic [XLEN-1:0] prog      [NUM_TESTS][PROG_WORDS];
    int              prog_len  [NUM_TESTS];
    wb_t             exp_wb    [NUM_TESTS][PROG_WORDS];
    int              exp_len   [NUM_TESTS];

    int seed;
    int errors;
    int passed;

    mips_core #(
        .IMEM_AW (8),
        .DMEM_AW (8)
    ) i_dut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_preload_en    (i_preload_en),
        .i_preload_addr  (i_preload_addr),
        .i_preload_instr (i_preload_instr),
        .o_wb            (o_wb)
    );

    always #2 i_clk = ~i_clk;

    // ----------------------------------------
    // Instruction encoders
    // ----------------------------------------
    function automatic logic [XLEN-1:0] enc_r(input logic [5:0] fn, input int rd,
                                              input int rs, input int rt);
        instr_u w;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = REG_AW'(rs);
        w.r.rt     = REG_AW'(rt);
        w.r.rd     = REG_AW'(rd);
        w.r.shamt  = '0;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] enc_i(input logic [5:0] op, input int rt,
                                              input int rs, input int imm);
        instr_u w;
        w.i.opcode = op;
        w.i.rs     = REG_AW'(rs);
        w.i.rt     = REG_AW'(rt);
        w.i.imm    = 16'(imm);
        return w;
    endfunction

    function automatic logic [XLEN-1:0] sext16(input logic [15:0] v);
        return {{(XLEN-16){v[15]}}, v};
    endfunction

    // Mixed signs mean the negative operand is the smaller one
    function automatic logic [XLEN-1:0] less(input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
        if (a[XLEN-1] != b[XLEN-1]) begin
            return XLEN'(a[XLEN-1]);
        end
        return (a < b) ? 32'd1 : 32'd0;
    endfunction

    task automatic add_instr(input int t, input logic [XLEN-1:0] word);
        prog[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic add_write(input int t, input int dest, input logic [XLEN-1:0] data);
        wb_t w;
        w.reg_write = 1'b1;
        w.dest      = REG_AW'(dest);
        w.data      = data;
        exp_wb[t][exp_len[t]] = w;
        exp_len[t]++;
    endtask

    // ----------------------------------------
    // Test table
    // ----------------------------------------
    task automatic build_tests();
        logic [15:0]     imm_a;
        logic [15:0]     imm_b;
        logic [15:0]     imm_c;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] v;
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            exp_len[t]  = 0;
        end
        imm_a = 16'($random(seed));
        imm_b = 16'($random(seed));
        imm_c = 16'($random(seed));
        // One negative and one positive operand so SLT sees a sign difference
        imm_a[15] = 1'b1;
        imm_b[15] = 1'b0;

        // ALU ops on two random operands
        a = sext16(imm_a);
        b = sext16(imm_b);
        test_name[0] = "arith";
        add_instr(0, enc_i(OP_ADDI, 1, 0, int'(imm_a)));
        add_instr(0, enc_i(OP_ADDI, 2, 0, int'(imm_b)));
        add_instr(0, enc_r(FN_ADD, 3, 1, 2));
        add_instr(0, enc_r(FN_SUB, 4, 1, 2));
        add_instr(0, enc_r(FN_AND, 5, 1, 2));
        add_instr(0, enc_r(FN_OR, 6, 1, 2));
        add_instr(0, enc_r(FN_SLT, 7, 1, 2));
        add_instr(0, enc_r(FN_SLT, 8, 2, 1));
        add_write(0, 1, a);
        add_write(0, 2, b);
        add_write(0, 3, a + b);
        add_write(0, 4, a - b);
        add_write(0, 5, a & b);
        add_write(0, 6, a | b);
        add_write(0, 7, less(a, b));
        add_write(0, 8, less(b, a));

        // Dependencies at distance 1, 2 and 3
        test_name[1] = "forward";
        add_instr(1, enc_i(OP_ADDI, 1, 0, 5));
        add_instr(1, enc_i(OP_ADDI, 2, 1, 7));
        add_instr(1, enc_i(OP_ADDI, 3, 0, 100));
        add_instr(1, enc_r(FN_ADD, 4, 2, 1));
        add_instr(1, enc_r(FN_SUB, 5, 4, 3));
        add_instr(1, enc_r(FN_OR, 6, 5, 4));
        add_instr(1, enc_r(FN_ADD, 7, 3, 6));
        a = 32'd17;
        b = a - 32'd100;
        add_write(1, 1, 32'd5);
        add_write(1, 2, 32'd12);
        add_write(1, 3, 32'd100);
        add_write(1, 4, a);
        add_write(1, 5, b);
        add_write(1, 6, b | a);
        add_write(1, 7, 32'd100 + (b | a));

        // Store, load and load-use stalls on rs and on SW data
        v = sext16(imm_c);
        test_name[2] = "load_use";
        add_instr(2, enc_i(OP_ADDI, 1, 0, int'(imm_c)));
        add_instr(2, enc_i(OP_ADDI, 2, 0, 64));
        add_instr(2, enc_i(OP_SW, 1, 2, 8));
        add_instr(2, enc_i(OP_LW, 3, 2, 8));
        add_instr(2, enc_r(FN_ADD, 4, 3, 1));
        add_instr(2, enc_i(OP_LW, 5, 2, 8));
        add_instr(2, enc_i(OP_SW, 5, 2, 12));
        add_instr(2, enc_i(OP_LW, 6, 2, 12));
        add_instr(2, enc_r(FN_SUB, 7, 6, 2));
        add_write(2, 1, v);
        add_write(2, 2, 32'd64);
        add_write(2, 3, v);
        add_write(2, 4, v + v);
        add_write(2, 5, v);
        add_write(2, 6, v);
        add_write(2, 7, v - 32'd64);

        // Taken BEQ skips words 3 to 5 and the second BEQ falls through
        test_name[3] = "branch";
        add_instr(3, enc_i(OP_ADDI, 1, 0, 3));
        add_instr(3, enc_i(OP_ADDI, 2, 0, 3));
        add_instr(3, enc_i(OP_BEQ, 2, 1, 3));
        add_instr(3, enc_i(OP_ADDI, 3, 0, 1));
        add_instr(3, enc_i(OP_ADDI, 4, 0, 2));
        add_instr(3, enc_i(OP_ADDI, 5, 0, 3));
        add_instr(3, enc_i(OP_ADDI, 6, 0, 4));
        add_instr(3, enc_i(OP_BEQ, 6, 1, 1));
        add_instr(3, enc_i(OP_ADDI, 7, 0, 5));
        add_write(3, 1, 32'd3);
        add_write(3, 2, 32'd3);
        add_write(3, 6, 32'd4);
        add_write(3, 7, 32'd5);

        // Register 0 ignores writes and reads back zero
        test_name[4] = "reset_r0";
        add_instr(4, enc_i(OP_ADDI, 0, 0, 55));
        add_instr(4, enc_r(FN_ADD, 1, 0, 0));
        add_instr(4, enc_i(OP_ADDI, 2, 0, 9));
        add_instr(4, enc_r(FN_OR, 3, 2, 0));
        add_write(4, 1, 32'd0);
        add_write(4, 2, 32'd9);
        add_write(4, 3, 32'd9);

        // Branch to self parks the PC at the end of every program
        for (int t = 0; t < NUM_TESTS; t++) begin
            add_instr(t, enc_i(OP_BEQ, 0, 0, -1));
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_wb(input string test, input int idx, input wb_t got, input wb_t exp);
        if (got.dest !== exp.dest) begin
            $display("[ERROR] t=%0t %s write %0d o_wb.dest: got %0d, expected %0d",
                     $time, test, idx, got.dest, exp.dest);
            errors++;
        end
        if (got.data !== exp.data) begin
            $display("[ERROR] t=%0t %s write %0d o_wb.data: got %h, expected %h",
                     $time, test, idx, got.data, exp.data);
            errors++;
        end
    endtask

    task automatic check_count(input string test, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] t=%0t %s write count: got %0d, expected %0d",
                     $time, test, got, exp);
            errors++;
        end
    endtask

    // Program words go in one per reset cycle and spare words get addressed no-ops
    task automatic reset_and_preload(input int t);
        @(negedge i_clk);
        i_rst = 1'b0;
        for (int a = 0; a < PROG_WORDS; a++) begin
            i_preload_en    = 1'b1;
            i_preload_addr  = 32'(a);
            i_preload_instr = (a < prog_len[t]) ? prog[t][a] : enc_i(OP_ADDI, 0, 0, a);
            @(negedge i_clk);
            if (o_wb.reg_write) begin
                $display("Test %s: a register write showed up on o_wb during reset",
                         test_name[t]);
                errors++;
            end
        end
        i_preload_en = 1'b0;
        i_rst        = 1'b1;
    endtask

    task automatic run_test(input int t);
        wb_t got [$];
        int  cycles;
        int  err_before;
        err_before = errors;
        reset_and_preload(t);
        cycles = 0;
        while ((got.size() < exp_len[t]) && (cycles < WB_TIMEOUT)) begin
            @(negedge i_clk);
            cycles++;
            if (o_wb.reg_write) begin
                got.push_back(o_wb);
            end
        end
        if (got.size() < exp_len[t]) begin
            $display("Test %s: timed out, only %0d of %0d writes within %0d cycles",
                     test_name[t], got.size(), exp_len[t], WB_TIMEOUT);
            errors++;
        end
        // Any write in the quiet window is an extra one
        for (int k = 0; k < QUIET_CYC; k++) begin
            @(negedge i_clk);
            if (o_wb.reg_write) begin
                got.push_back(o_wb);
            end
        end
        check_count(test_name[t], got.size(), exp_len[t]);
        for (int k = 0; (k < got.size()) && (k < exp_len[t]); k++) begin
            check_wb(test_name[t], k, got[k], exp_wb[t][k]);
        end
        if (errors == err_before) begin
            passed++;
            $display("[PASS] %s: %0d writes", test_name[t], got.size());
        end else begin
            $display("[FAIL] %s: %0d errors", test_name[t], errors - err_before);
        end
    endtask

    initial begin
        i_clk           = 1'b0;
        i_rst           = 1'b0;
        i_preload_en    = 1'b0;
        i_preload_addr  = '0;
        i_preload_instr = '0;
        errors          = 0;
        passed          = 0;
        seed            = 32'h4816;
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, passed, NUM_TESTS - passed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== mips_core.f ====
hdl/mips_pkg.sv
hdl/instr_fetch.sv
hdl/reg_file.sv
hdl/instr_decode.sv
hdl/forward_unit.sv
hdl/execute.sv
hdl/mem_access.sv
hdl/mips_core.sv
sim/mips_core_sva.sv
sim/mips_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MIPS pipeline regression with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mips_core_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mips_core_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN" -f mips_core.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
